/* include/weight_consts.svh */
//==============================
// Weight distributor constants
// Lane count, data and address widths,
// prefetch queue depth
//==============================
`ifndef WEIGHT_CONSTS_SVH
`define WEIGHT_CONSTS_SVH

// Lanes per block, one flag bit each
`define LANES 8
// One compressed weight
`define DATA_WIDTH 8
// Holds 0 to LANES
`define COUNT_WIDTH 4

// Buffer address widths
`define FLAG_ADDR_WIDTH 6
`define WEI_ADDR_WIDTH 9

`define WEI_QUEUE_DEPTH 4

`endif

/* design/weightPkg.sv */
//==============================
// Weight distributor types
// Scatter FSM states and lane vectors
//==============================
`default_nettype none
`include "weight_consts.svh"

package weightPkg;

    // Scatter FSM
    typedef enum logic [1:0] {
        IDLE,
        WAITFLAGS,
        SCAN
    } scatterState;

    typedef logic [`DATA_WIDTH-1:0] weightT;
    // Lane 0 in the low bits
    typedef weightT [`LANES-1:0] denseBlockT;
    typedef logic [`LANES-1:0] flagWordT;

endpackage

`default_nettype wire

/* design/flagFetch.sv */
//==============================
// Flag fetch
// Reads one bitmap per fetch pulse from the
// flag buffer, registers it with its popcount
// and pulses flagValid
//==============================
`timescale 1ns/1ps
`default_nettype none
`include "weight_consts.svh"

module flagFetch (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         fetch,
    output logic                              flagRdEn,
    output logic [`FLAG_ADDR_WIDTH-1:0]       flagRdAddr,
    input  wire weightPkg::flagWordT          flagRdData,
    output weightPkg::flagWordT               flags,
    output logic [`COUNT_WIDTH-1:0]           flagCount,
    output logic                              flagValid
);

    // Fetch delayed one cycle, marks returning data
    logic fetchD;

    // Number of set bits in one bitmap
    function automatic logic [`COUNT_WIDTH-1:0] popCount(input weightPkg::flagWordT bits);
        logic [`COUNT_WIDTH-1:0] sum;
        sum = '0;
        for (int i = 0; i < `LANES; i++) begin
            sum = sum + {{(`COUNT_WIDTH-1){1'b0}}, bits[i]};
        end
        return sum;
    endfunction

    //==============================
    // Read side
    //==============================

    // Read straight on the fetch pulse
    assign flagRdEn = fetch;

    // Address wraps, no rewind
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flagRdAddr <= '0;
        end else if (fetch) begin
            flagRdAddr <= flagRdAddr + 1'b1;
        end
    end

    //==============================
    // Capture side
    //==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetchD    <= 1'b0;
            flagValid <= 1'b0;
        end else begin
            fetchD    <= fetch;
            // Data stable in the cycle after the read
            flagValid <= fetchD;
        end
    end

    // Bitmap and count captured together, single stage
    always_ff @(posedge clk) begin
        if (fetchD) begin
            flags     <= flagRdData;
            flagCount <= popCount(flagRdData);
        end
    end

endmodule

`default_nettype wire

/* design/weightFetch.sv */
//==============================
// Weight prefetch queue
// Reads compressed weights ahead into a small
// circular queue, serves pops to the scatter
// Occupancy counts the read in flight
//==============================
`timescale 1ns/1ps
`default_nettype none
`include "weight_consts.svh"

module weightFetch (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    output logic                            weiRdEn,
    output logic [`WEI_ADDR_WIDTH-1:0]      weiRdAddr,
    input  wire weightPkg::weightT          weiRdData,
    input  wire logic                       queuePop,
    output weightPkg::weightT               queueData,
    output logic                            queueEmpty
);

    localparam int ptrWidth = $clog2(`WEI_QUEUE_DEPTH);
    localparam int occWidth = ptrWidth + 1;

    // Queue storage
    weightPkg::weightT queueMem [`WEI_QUEUE_DEPTH];

    // Pointers carry one wrap bit
    logic [ptrWidth:0]    wrPtr;
    logic [ptrWidth:0]    rdPtr;
    // Stored entries plus read in flight
    logic [occWidth-1:0]  occupancy;
    logic [occWidth-1:0]  occNext;
    // Read issued last cycle, data on the bus now
    logic                 rdPending;

    //==============================
    // Read issue
    //==============================

    // Occupancy after this edge
    assign occNext = occupancy + occWidth'(weiRdEn) - occWidth'(queuePop);

    // Registered enable, equals occupancy < depth in its own cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiRdEn   <= 1'b0;
            occupancy <= '0;
            rdPending <= 1'b0;
        end else begin
            weiRdEn   <= (occNext < occWidth'(`WEI_QUEUE_DEPTH));
            occupancy <= occNext;
            rdPending <= weiRdEn;
        end
    end

    // Address wraps through the stream
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiRdAddr <= '0;
        end else if (weiRdEn) begin
            weiRdAddr <= weiRdAddr + 1'b1;
        end
    end

    //==============================
    // Queue
    //==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (rdPending) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (queuePop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // Returning data lands one cycle after its read
    always_ff @(posedge clk) begin
        if (rdPending) begin
            queueMem[wrPtr[ptrWidth-1:0]] <= weiRdData;
        end
    end

    // Head of queue, valid before the pop
    assign queueData  = queueMem[rdPtr[ptrWidth-1:0]];
    assign queueEmpty = (wrPtr == rdPtr);

    //==============================
    // Checks
    //==============================

    // Scatter only pops a stored weight
    assert property (@(posedge clk) disable iff (!rst_n) queuePop |-> !queueEmpty)
        else $error("weight queue popped while empty");

    // Reads stop once the queue plus in-flight read is full
    assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= occWidth'(`WEI_QUEUE_DEPTH))
        else $error("weight queue occupancy above depth");

endmodule

`default_nettype wire

/* design/weightScatter.sv */
//==============================
// Weight scatter
// Expands queued nonzero weights into a dense
// lane vector, one lane per cycle, zero where
// the flag is clear. Drives ready and the result
//==============================
`timescale 1ns/1ps
`default_nettype none
`include "weight_consts.svh"

module weightScatter (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       fetch,
    input  wire weightPkg::flagWordT        flags,
    input  wire logic [`COUNT_WIDTH-1:0]    flagCount,
    input  wire logic                       flagValid,
    input  wire weightPkg::weightT          queueData,
    input  wire logic                       queueEmpty,
    output logic                            queuePop,
    output logic                            ready,
    output logic                            weightsValid,
    output weightPkg::denseBlockT           denseWeights,
    output logic [`COUNT_WIDTH-1:0]         nonZeroCount
);

    localparam int laneIdxWidth = $clog2(`LANES);

    weightPkg::scatterState     state;
    logic [laneIdxWidth-1:0]    laneIdx;

    // Current block bitmap and count
    weightPkg::flagWordT        flagsReg;
    logic [`COUNT_WIDTH-1:0]    countReg;

    // Block under construction
    weightPkg::denseBlockT      work;
    weightPkg::denseBlockT      nextBlock;
    weightPkg::weightT          laneValue;
    logic                       laneSet;
    logic                       laneAdvance;
    logic                       lastLane;

    //==============================
    // Lane datapath
    //==============================

    assign laneSet     = flagsReg[laneIdx];
    assign laneValue   = laneSet ? queueData : '0;
    // Set flag waits for a weight
    assign laneAdvance = (state == weightPkg::SCAN) && (!laneSet || !queueEmpty);
    assign queuePop    = (state == weightPkg::SCAN) && laneSet && !queueEmpty;
    assign lastLane    = (laneIdx == laneIdxWidth'(`LANES - 1));

    // Work block with the current lane filled in
    always_comb begin
        nextBlock          = work;
        nextBlock[laneIdx] = laneValue;
    end

    always_ff @(posedge clk) begin
        if (state == weightPkg::WAITFLAGS && flagValid) begin
            flagsReg <= flags;
            countReg <= flagCount;
        end
        if (laneAdvance) begin
            work <= nextBlock;
        end
    end

    //==============================
    // Control FSM
    //==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= weightPkg::IDLE;
            laneIdx      <= '0;
            ready        <= 1'b1;
            weightsValid <= 1'b0;
            denseWeights <= '0;
            nonZeroCount <= '0;
        end else begin
            weightsValid <= 1'b0;
            // Ready back one cycle after the result
            if (weightsValid) begin
                ready <= 1'b1;
            end
            case (state)
                weightPkg::IDLE: begin
                    if (fetch) begin
                        state <= weightPkg::WAITFLAGS;
                        ready <= 1'b0;
                    end
                end
                weightPkg::WAITFLAGS: begin
                    if (flagValid) begin
                        state   <= weightPkg::SCAN;
                        laneIdx <= '0;
                    end
                end
                weightPkg::SCAN: begin
                    if (laneAdvance) begin
                        laneIdx <= laneIdx + laneIdxWidth'(1);
                        if (lastLane) begin
                            state        <= weightPkg::IDLE;
                            weightsValid <= 1'b1;
                            denseWeights <= nextBlock;
                            nonZeroCount <= countReg;
                        end
                    end
                end
                default: state <= weightPkg::IDLE;
            endcase
        end
    end

    //==============================
    // Checks
    //==============================

    // Fetch only accepted while idle
    assert property (@(posedge clk) disable iff (!rst_n) fetch |-> state == weightPkg::IDLE)
        else $error("fetch outside IDLE");

    // Flag fetch answers only an outstanding request
    assert property (@(posedge clk) disable iff (!rst_n)
        flagValid |-> state == weightPkg::WAITFLAGS)
        else $error("flagValid outside WAITFLAGS");

endmodule

`default_nettype wire

/* design/weightDistributor.sv */
//==============================
// Sparse weight distributor
// Top level: flag fetch, weight prefetch and
// scatter joined to the two buffer ports
//==============================
`timescale 1ns/1ps
`default_nettype none
`include "weight_consts.svh"

module weightDistributor (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       fetch,
    output logic                            ready,
    // Flag buffer
    output logic                            flagRdEn,
    output logic [`FLAG_ADDR_WIDTH-1:0]     flagRdAddr,
    input  wire weightPkg::flagWordT        flagRdData,
    // Weight buffer
    output logic                            weiRdEn,
    output logic [`WEI_ADDR_WIDTH-1:0]      weiRdAddr,
    input  wire weightPkg::weightT          weiRdData,
    // Result
    output logic                            weightsValid,
    output weightPkg::denseBlockT           denseWeights,
    output logic [`COUNT_WIDTH-1:0]         nonZeroCount
);

    // Flag path
    weightPkg::flagWordT        flags;
    logic [`COUNT_WIDTH-1:0]    flagCount;
    logic                       flagValid;

    // Queue path
    weightPkg::weightT          queueData;
    logic                       queueEmpty;
    logic                       queuePop;

    flagFetch flagFetch0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch      (fetch),
        .flagRdEn   (flagRdEn),
        .flagRdAddr (flagRdAddr),
        .flagRdData (flagRdData),
        .flags      (flags),
        .flagCount  (flagCount),
        .flagValid  (flagValid)
    );

    weightFetch weightFetch0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .weiRdEn    (weiRdEn),
        .weiRdAddr  (weiRdAddr),
        .weiRdData  (weiRdData),
        .queuePop   (queuePop),
        .queueData  (queueData),
        .queueEmpty (queueEmpty)
    );

    weightScatter weightScatter0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch        (fetch),
        .flags        (flags),
        .flagCount    (flagCount),
        .flagValid    (flagValid),
        .queueData    (queueData),
        .queueEmpty   (queueEmpty),
        .queuePop     (queuePop),
        .ready        (ready),
        .weightsValid (weightsValid),
        .denseWeights (denseWeights),
        .nonZeroCount (nonZeroCount)
    );

endmodule

`default_nettype wire

/* tests/tbWeightDistributor.sv */
//==============================
// Sparse weight distributor testbench
// Flag and weight buffer models, reference
// scatter model, random bitmaps with idle gaps
//==============================
`timescale 1ns/1ps
`default_nettype none
`include "weight_consts.svh"

module tbWeightDistributor;

    localparam int flagDepth    = 1 << `FLAG_ADDR_WIDTH;
    localparam int weiDepth     = 1 << `WEI_ADDR_WIDTH;
    localparam int waitLimit    = 200;
    localparam int randomBlocks = 40;
    localparam int gapBlocks    = 20;

    logic                           clk;
    logic                           rst_n;
    logic                           fetch;
    logic                           ready;
    logic                           flagRdEn;
    logic [`FLAG_ADDR_WIDTH-1:0]    flagRdAddr;
    weightPkg::flagWordT            flagRdData = '0;
    logic                           weiRdEn;
    logic [`WEI_ADDR_WIDTH-1:0]     weiRdAddr;
    weightPkg::weightT              weiRdData = '0;
    logic                           weightsValid;
    weightPkg::denseBlockT          denseWeights;
    logic [`COUNT_WIDTH-1:0]        nonZeroCount;

    // Buffer contents
    weightPkg::flagWordT            flagMem [flagDepth];
    weightPkg::weightT              weiMem [weiDepth];

    // Read requests taken at the last edge
    logic                           flagEnQ;
    logic [`FLAG_ADDR_WIDTH-1:0]    flagAddrQ;
    logic                           weiEnQ;
    logic [`WEI_ADDR_WIDTH-1:0]     weiAddrQ;

    integer seed;
    int     errorCount;
    int     numChecks;
    int     countErrs;
    // Next block to fetch, next stream weight expected
    int     blockIdx;
    int     streamPtr;
    bit     aborted;

    weightDistributor dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch        (fetch),
        .ready        (ready),
        .flagRdEn     (flagRdEn),
        .flagRdAddr   (flagRdAddr),
        .flagRdData   (flagRdData),
        .weiRdEn      (weiRdEn),
        .weiRdAddr    (weiRdAddr),
        .weiRdData    (weiRdData),
        .weightsValid (weightsValid),
        .denseWeights (denseWeights),
        .nonZeroCount (nonZeroCount)
    );

    // 40 ns period
    always #20 clk = ~clk;

    //==============================
    // Buffer models
    //==============================

    always @(posedge clk) begin
        flagEnQ   <= flagRdEn;
        flagAddrQ <= flagRdAddr;
        weiEnQ    <= weiRdEn;
        weiAddrQ  <= weiRdAddr;
    end

    // Data held for the whole cycle after the read edge
    always @(posedge clk) begin
        #2;
        if (flagEnQ) begin
            flagRdData = flagMem[flagAddrQ];
        end
        if (weiEnQ) begin
            weiRdData = weiMem[weiAddrQ];
        end
    end

    function automatic weightPkg::weightT randomWeight();
        logic [31:0] rnd;
        rnd = $random(seed);
        // Stream holds nonzero weights only
        return (rnd[`DATA_WIDTH-1:0] == '0) ? weightPkg::weightT'(1) : rnd[`DATA_WIDTH-1:0];
    endfunction

    task automatic buildBuffers;
        logic [31:0] rnd;
        int ptr;
        ptr = 0;
        for (int k = 0; k < flagDepth; k++) begin
            rnd = $random(seed);
            flagMem[k] = rnd[`LANES-1:0];
        end
        // Corner bitmaps right after the random run
        flagMem[randomBlocks]     = '0;
        flagMem[randomBlocks + 1] = '1;
        // One weight per set bit, block order
        for (int k = 0; k < flagDepth; k++) begin
            for (int i = 0; i < `LANES; i++) begin
                if (flagMem[k][i] && ptr < weiDepth) begin
                    weiMem[ptr] = randomWeight();
                    ptr++;
                end
            end
        end
        // Tail only touched by read-ahead
        while (ptr < weiDepth) begin
            weiMem[ptr] = randomWeight();
            ptr++;
        end
    endtask

    //==============================
    // Reference model and checks
    //==============================

    task automatic expectBlock(input int k, output weightPkg::denseBlockT blk,
                               output logic [`COUNT_WIDTH-1:0] cnt);
        weightPkg::flagWordT bits;
        bits = flagMem[k];
        blk  = '0;
        cnt  = '0;
        for (int i = 0; i < `LANES; i++) begin
            if (bits[i]) begin
                blk[i] = weiMem[streamPtr];
                streamPtr++;
                cnt++;
            end
        end
    endtask

    task automatic checkBlock(input string name, input weightPkg::denseBlockT expected,
                              input weightPkg::denseBlockT actual);
        numChecks++;
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCount(input string name, input logic [`COUNT_WIDTH-1:0] expected,
                              input logic [`COUNT_WIDTH-1:0] actual);
        numChecks++;
        if (actual !== expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
            countErrs++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        numChecks++;
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            errorCount++;
        end
    endtask

    //==============================
    // Stimulus
    //==============================

    // Sample and drive point 2 ns past the edge
    task automatic tick;
        @(posedge clk);
        #2;
    endtask

    task automatic waitReady;
        int cycles;
        cycles = 0;
        while (!ready && cycles < waitLimit) begin
            tick();
            cycles++;
        end
        if (!ready) begin
            $display("Timeout: ready never returned high for block %0d", blockIdx);
            errorCount++;
            aborted = 1'b1;
        end
    endtask

    task automatic waitValid;
        int cycles;
        cycles = 0;
        while (!weightsValid && cycles < waitLimit) begin
            tick();
            cycles++;
        end
        if (!weightsValid) begin
            $display("Timeout: no weightsValid pulse for block %0d", blockIdx);
            errorCount++;
            aborted = 1'b1;
        end
    endtask

    // Idle gap, one fetch, then compare the finished block
    task automatic runBlock(input string name, input int gap);
        weightPkg::denseBlockT       expBlock;
        logic [`COUNT_WIDTH-1:0]     expCount;
        repeat (gap) tick();
        // Ready must already be back when the fetch is due
        checkFlag({name, " ready at fetch"}, 1'b1, ready);
        waitReady();
        if (!aborted) begin
            fetch = 1'b1;
            tick();
            fetch = 1'b0;
            waitValid();
        end
        if (!aborted) begin
            expectBlock(blockIdx, expBlock, expCount);
            checkBlock(name, expBlock, denseWeights);
            checkCount(name, expCount, nonZeroCount);
            // Ready returns the cycle after weightsValid
            tick();
        end
        blockIdx++;
    endtask

    initial begin
        logic [31:0] rnd;
        int errBefore;
        int countBefore;
        seed       = 32'he363_83fa;
        clk        = 1'b0;
        rst_n      = 1'b0;
        fetch      = 1'b0;
        errorCount = 0;
        numChecks  = 0;
        countErrs  = 0;
        blockIdx   = 0;
        streamPtr  = 0;
        aborted    = 1'b0;
        buildBuffers();

        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        tick();

        // Reset state
        errBefore = errorCount;
        checkFlag("reset ready", 1'b1, ready);
        checkFlag("reset weightsValid", 1'b0, weightsValid);
        checkBlock("reset denseWeights", '0, denseWeights);
        checkCount("reset nonZeroCount", '0, nonZeroCount);
        $display("Test 1 reset state: %0d errors", errorCount - errBefore);

        // Back-to-back random bitmaps
        errBefore   = errorCount;
        countBefore = countErrs;
        for (int k = 0; k < randomBlocks && !aborted; k++) begin
            runBlock($sformatf("random block %0d", k), 0);
        end
        $display("Test 2 random blocks: %0d errors",
                 (errorCount - errBefore) - (countErrs - countBefore));
        $display("Test 3 nonzero counts: %0d errors", countErrs - countBefore);

        // All zeros then all ones
        errBefore = errorCount;
        if (!aborted) begin
            runBlock("all zeros block", 0);
        end
        if (!aborted) begin
            runBlock("all ones block", 0);
        end
        $display("Test 4 corner bitmaps: %0d errors", errorCount - errBefore);

        // Idle gaps of 0 to 5 cycles between blocks
        errBefore = errorCount;
        for (int k = 0; k < gapBlocks && !aborted; k++) begin
            rnd = $random(seed);
            runBlock($sformatf("gap block %0d", k), int'(rnd % 6));
        end
        $display("Test 5 idle gaps: %0d errors", errorCount - errBefore);

        $display("Summary: %0d checks, %0d errors", numChecks, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
design/weightPkg.sv
design/flagFetch.sv
design/weightFetch.sv
design/weightScatter.sv
design/weightDistributor.sv
tests/tbWeightDistributor.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the weight distributor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbWeightDistributor -f compile.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }
